// ==== rtl/dbg_pkg.sv ====
/*
 * Shared definitions for the debug access port: command codes, bus widths,
 * memory map, status byte layout and the byte-channel / Wishbone structs.
 * Compile first; modules import it inside their bodies.
 */

package dbg_pkg;

    // ------------------------------------------------------------------------
    // command codes, ack byte is command ^ 8'h80
    // ------------------------------------------------------------------------
    localparam logic [7:0] CMD_NOP       = 8'h00;
    localparam logic [7:0] CMD_STATUS    = 8'h01;
    localparam logic [7:0] CMD_READ      = 8'h02;
    localparam logic [7:0] CMD_WRITE     = 8'h03;
    localparam logic [7:0] ACK_WRITE_END = 8'hc3;

    // bus geometry
    localparam int DAT_SIZE  = 2;
    localparam int DAT_WIDTH = 32;
    localparam int SEL_WIDTH = 4;
    localparam int ADR_WIDTH = 30;
    localparam int ADR_BYTES = 4;

    // memory map, word addresses
    localparam int          REGION_BIT   = 10;
    localparam int          RAM_WORDS    = 256;
    localparam logic [31:0] REG_ID_VALUE = 32'h5a3c_0001;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       endian;
        logic [2:0] dat_size;
        logic [3:0] adr_bytes;
    } status_fields_t;

    // built from fields, sent as a raw byte
    typedef union packed {
        logic [7:0]     raw;
        status_fields_t f;
    } status_t;

    // one direction of the byte channel, ready runs the other way
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } comm_byte_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [ADR_WIDTH-1:0] adr;
        logic [SEL_WIDTH-1:0] sel;
        logic [DAT_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [DAT_WIDTH-1:0] dat;
    } wb_rsp_t;

    // byte-lane merge of a bus write into the stored word
    function automatic logic [DAT_WIDTH-1:0] merge_lanes(
        input logic [DAT_WIDTH-1:0] old_word,
        input logic [DAT_WIDTH-1:0] wr_data,
        input logic [SEL_WIDTH-1:0] sel
    );
        logic [DAT_WIDTH-1:0] word;
        word = old_word;
        for (int b = 0; b < SEL_WIDTH; b++) begin
            if (sel[b]) begin
                word[b*8 +: 8] = wr_data[b*8 +: 8];
            end
        end
        return word;
    endfunction

endpackage

// ==== rtl/dbg_comm_bridge.sv ====
/*
 * Command decoder between the host byte channel and a Wishbone classic
 * master. Handles nop, status, read and write; byte order of the address
 * and of the data lanes follows the endian_i strap.
 */

`timescale 1ns/1ps

module dbg_comm_bridge (
    input  logic                clk,
    input  logic                reset,
    input  logic                endian_i,
    input  dbg_pkg::comm_byte_t rx_i,
    output logic                rx_ready_o,
    output dbg_pkg::comm_byte_t tx_o,
    input  logic                tx_ready_i,
    output dbg_pkg::wb_req_t    wb_req_o,
    input  dbg_pkg::wb_rsp_t    wb_rsp_i
);
    import dbg_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ACK,
        ST_STATUS,
        ST_ADR,
        ST_SIZE,
        ST_WRITE,
        ST_WRITE_END,
        ST_READ_START,
        ST_READ
    } state_t;

    state_t                       state_q;
    logic [7:0]                   cmd_q;
    logic [7:0]                   size_q;
    logic [$clog2(ADR_BYTES)-1:0] cnt_q;
    logic [8*ADR_BYTES-1:0]       baddr_q;
    logic [DAT_SIZE-1:0]          ofs_q;
    logic                         rx_rdy_q;
    comm_byte_t                   tx_q;
    wb_req_t                      req_q;
    logic [DAT_WIDTH-1:0]         rd_data_q;
    logic                         rd_valid_q;

    status_t                      status;
    logic [$clog2(ADR_BYTES)-1:0] abyte;
    logic [DAT_SIZE-1:0]          lane;
    logic                         rx_fire;
    logic                         tx_free;
    logic                         bus_ack;

    // lanes touched by up to cnt bytes starting at offset ofs
    function automatic logic [SEL_WIDTH-1:0] lane_mask(
        input logic [DAT_SIZE-1:0] ofs,
        input logic [7:0]          cnt,
        input logic                big
    );
        logic [SEL_WIDTH-1:0] m;
        m = '0;
        for (int k = 0; k < SEL_WIDTH; k++) begin
            if (k >= int'(ofs) && k - int'(ofs) < int'(cnt)) begin
                m[big ? SEL_WIDTH - 1 - k : k] = 1'b1;
            end
        end
        return m;
    endfunction

    always_comb begin
        status.f.endian    = endian_i;
        status.f.dat_size  = 3'(DAT_SIZE);
        status.f.adr_bytes = 4'(ADR_BYTES);
    end

    // big endian mirrors byte positions
    assign abyte   = cnt_q ^ {$bits(cnt_q){endian_i}};
    assign lane    = ofs_q ^ {DAT_SIZE{endian_i}};
    assign rx_fire = rx_i.valid & rx_ready_o;
    assign tx_free = ~tx_q.valid | tx_ready_i;
    assign bus_ack = req_q.stb & wb_rsp_i.ack;

    // ------------------------------------------------------------------------
    // command state machine
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= ST_IDLE;
            rx_rdy_q   <= 1'b1;
            tx_q.valid <= 1'b0;
            req_q.cyc  <= 1'b0;
            req_q.stb  <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            if (tx_ready_i) begin
                tx_q.valid <= 1'b0;
            end
            // close the cycle and step to the next word
            if (bus_ack) begin
                req_q.cyc <= 1'b0;
                req_q.stb <= 1'b0;
                req_q.adr <= req_q.adr + 1'b1;
            end

            case (state_q)
            ST_IDLE: begin
                if (rx_fire) begin
                    cmd_q      <= rx_i.data;
                    tx_q.data  <= rx_i.data ^ 8'h80;
                    tx_q.valid <= 1'b1;
                    rx_rdy_q   <= 1'b0;
                    state_q    <= ST_ACK;
                end
            end

            ST_ACK: begin
                if (tx_ready_i) begin
                    cnt_q <= '0;
                    if (cmd_q == CMD_STATUS) begin
                        tx_q.data  <= status.raw;
                        tx_q.valid <= 1'b1;
                        state_q    <= ST_STATUS;
                    end else if (cmd_q == CMD_READ || cmd_q == CMD_WRITE) begin
                        rx_rdy_q <= 1'b1;
                        state_q  <= ST_ADR;
                    end else begin
                        // nop and unknown codes end with the ack
                        rx_rdy_q <= 1'b1;
                        state_q  <= ST_IDLE;
                    end
                end
            end

            ST_STATUS, ST_WRITE_END: begin
                if (tx_ready_i) begin
                    rx_rdy_q <= 1'b1;
                    state_q  <= ST_IDLE;
                end
            end

            ST_ADR: begin
                if (rx_fire) begin
                    baddr_q[abyte*8 +: 8] <= rx_i.data;
                    cnt_q                 <= cnt_q + 1'b1;
                    if (int'(cnt_q) == ADR_BYTES - 1) begin
                        state_q <= ST_SIZE;
                    end
                end
            end

            ST_SIZE: begin
                if (rx_fire) begin
                    size_q    <= rx_i.data;
                    req_q.adr <= baddr_q[8*ADR_BYTES-1:DAT_SIZE];
                    ofs_q     <= baddr_q[DAT_SIZE-1:0];
                    req_q.we  <= (cmd_q == CMD_WRITE);
                    req_q.sel <= '0;
                    if (cmd_q != CMD_WRITE) begin
                        rx_rdy_q <= 1'b0;
                        state_q  <= (rx_i.data == 8'd0) ? ST_READ : ST_READ_START;
                    end else if (rx_i.data == 8'd0) begin
                        rx_rdy_q   <= 1'b0;
                        tx_q.data  <= ACK_WRITE_END;
                        tx_q.valid <= 1'b1;
                        state_q    <= ST_WRITE_END;
                    end else begin
                        state_q <= ST_WRITE;
                    end
                end
            end

            // ------------------------------------------------------------------------
            // write: gather bytes into lanes, one bus write per word
            // ------------------------------------------------------------------------
            ST_WRITE: begin
                if (rx_fire) begin
                    req_q.dat[lane*8 +: 8] <= rx_i.data;
                    req_q.sel[lane]        <= 1'b1;
                    ofs_q                  <= ofs_q + 1'b1;
                    size_q                 <= size_q - 1'b1;
                    if (size_q == 8'd1 || &ofs_q) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                    end
                    if (size_q == 8'd1) begin
                        rx_rdy_q <= 1'b0;
                    end
                end
                if (bus_ack) begin
                    req_q.sel <= '0;
                    if (size_q == 8'd0) begin
                        tx_q.data  <= ACK_WRITE_END;
                        tx_q.valid <= 1'b1;
                        state_q    <= ST_WRITE_END;
                    end
                end
            end

            // ------------------------------------------------------------------------
            // read: fetch a word, then stream its bytes out
            // ------------------------------------------------------------------------
            ST_READ_START: begin
                req_q.sel  <= lane_mask(ofs_q, size_q, endian_i);
                req_q.cyc  <= 1'b1;
                req_q.stb  <= 1'b1;
                rd_valid_q <= 1'b0;
                state_q    <= ST_READ;
            end

            ST_READ: begin
                if (bus_ack) begin
                    rd_data_q  <= wb_rsp_i.dat;
                    rd_valid_q <= 1'b1;
                end
                if (size_q == 8'd0) begin
                    // wait for the last byte to leave
                    if (tx_free) begin
                        rx_rdy_q <= 1'b1;
                        state_q  <= ST_IDLE;
                    end
                end else if (rd_valid_q && tx_free) begin
                    tx_q.data  <= rd_data_q[lane*8 +: 8];
                    tx_q.valid <= 1'b1;
                    ofs_q      <= ofs_q + 1'b1;
                    size_q     <= size_q - 1'b1;
                    if (size_q == 8'd1 || &ofs_q) begin
                        rd_valid_q <= 1'b0;
                    end
                    if (size_q != 8'd1 && &ofs_q) begin
                        req_q.sel <= lane_mask('0, size_q - 8'd1, endian_i);
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                    end
                end
            end

            default: begin
                state_q <= ST_IDLE;
            end
            endcase
        end
    end

    // no new byte while a bus cycle is open
    assign rx_ready_o = rx_rdy_q & ~req_q.cyc;
    assign tx_o       = tx_q;
    assign wb_req_o   = req_q;

endmodule

// ==== rtl/dbg_scratch_ram.sv ====
/*
 * Scratch RAM on the Wishbone bus, 256 words with byte-lane writes.
 * Ack and read data come one cycle after the strobe is seen.
 */

`timescale 1ns/1ps

module dbg_scratch_ram (
    input  logic             clk,
    input  logic             reset,
    input  dbg_pkg::wb_req_t req_i,
    output dbg_pkg::wb_rsp_t rsp_o
);
    import dbg_pkg::*;

    logic [DAT_WIDTH-1:0]         mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0] idx;
    logic                         access;
    logic                         ack_q;
    logic [DAT_WIDTH-1:0]         rd_q;

    assign idx = req_i.adr[$clog2(RAM_WORDS)-1:0];

    // one ack per strobe, not repeated while the master drops stb
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && req_i.we) begin
            mem[idx] <= merge_lanes(mem[idx], req_i.dat, req_i.sel);
        end
        rd_q <= mem[idx];
    end

    assign rsp_o = '{ack: ack_q, dat: rd_q};

endmodule

// ==== rtl/dbg_reg_bank.sv ====
/*
 * Register bank slave: two read/write registers, a fixed identification
 * word and a count of write cycles to the bank.
 * Word index is address bits 1:0, one-cycle ack like the RAM.
 */

`timescale 1ns/1ps

module dbg_reg_bank (
    input  logic             clk,
    input  logic             reset,
    input  dbg_pkg::wb_req_t req_i,
    output dbg_pkg::wb_rsp_t rsp_o
);
    import dbg_pkg::*;

    logic [DAT_WIDTH-1:0] ctrl_q [2];
    logic [DAT_WIDTH-1:0] wr_cnt_q;
    logic [DAT_WIDTH-1:0] rd_q;
    logic [1:0]           idx;
    logic                 access;
    logic                 ack_q;

    assign idx    = req_i.adr[1:0];
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q     <= 1'b0;
            ctrl_q[0] <= '0;
            ctrl_q[1] <= '0;
            wr_cnt_q  <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                // every write counts, even to read-only words
                wr_cnt_q <= wr_cnt_q + 1'b1;
                if (!idx[1]) begin
                    ctrl_q[idx[0]] <= merge_lanes(ctrl_q[idx[0]], req_i.dat, req_i.sel);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        case (idx)
        2'd0, 2'd1: rd_q <= ctrl_q[idx[0]];
        2'd2:       rd_q <= REG_ID_VALUE;
        default:    rd_q <= wr_cnt_q;
        endcase
    end

    assign rsp_o = '{ack: ack_q, dat: rd_q};

endmodule

// ==== rtl/dbg_wb_decoder.sv ====
/*
 * Wishbone address decoder for one master and two slaves.
 * REGION_BIT picks the register bank over the RAM; both regions alias
 * across the rest of the address space.
 */

`timescale 1ns/1ps

module dbg_wb_decoder (
    input  logic             clk,
    input  logic             reset,
    input  dbg_pkg::wb_req_t m_req_i,
    output dbg_pkg::wb_rsp_t m_rsp_o,
    output dbg_pkg::wb_req_t ram_req_o,
    input  dbg_pkg::wb_rsp_t ram_rsp_i,
    output dbg_pkg::wb_req_t reg_req_o,
    input  dbg_pkg::wb_rsp_t reg_rsp_i
);
    import dbg_pkg::*;

    logic hit_reg;
    logic reg_active_q;

    assign hit_reg = m_req_i.adr[REGION_BIT];

    // address, data and sel fan out, only cyc/stb are steered
    always_comb begin
        ram_req_o     = m_req_i;
        ram_req_o.cyc = m_req_i.cyc & ~hit_reg;
        ram_req_o.stb = m_req_i.stb & ~hit_reg;
        reg_req_o     = m_req_i;
        reg_req_o.cyc = m_req_i.cyc & hit_reg;
        reg_req_o.stb = m_req_i.stb & hit_reg;
    end

    // owner of the open cycle, valid by the time its ack arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_active_q <= 1'b0;
        end else if (m_req_i.cyc && m_req_i.stb) begin
            reg_active_q <= hit_reg;
        end
    end

    assign m_rsp_o = reg_active_q ? reg_rsp_i : ram_rsp_i;

endmodule

// ==== rtl/dbg_top.sv ====
/*
 * Debug access port top level. Host byte channel in and out, the bridge
 * masters a Wishbone bus shared by the scratch RAM and the register bank.
 */

`timescale 1ns/1ps

module dbg_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                endian_i,
    input  dbg_pkg::comm_byte_t rx_i,
    output logic                rx_ready_o,
    output dbg_pkg::comm_byte_t tx_o,
    input  logic                tx_ready_i
);
    import dbg_pkg::*;

    wb_req_t m_req;
    wb_rsp_t m_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    wb_req_t reg_req;
    wb_rsp_t reg_rsp;

    dbg_comm_bridge u_bridge (
        .clk        (clk),
        .reset      (reset),
        .endian_i   (endian_i),
        .rx_i       (rx_i),
        .rx_ready_o (rx_ready_o),
        .tx_o       (tx_o),
        .tx_ready_i (tx_ready_i),
        .wb_req_o   (m_req),
        .wb_rsp_i   (m_rsp)
    );

    dbg_wb_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .m_req_i   (m_req),
        .m_rsp_o   (m_rsp),
        .ram_req_o (ram_req),
        .ram_rsp_i (ram_rsp),
        .reg_req_o (reg_req),
        .reg_rsp_i (reg_rsp)
    );

    // ------------------------------------------------------------------------
    // slaves
    // ------------------------------------------------------------------------
    dbg_scratch_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    dbg_reg_bank u_regs (
        .clk   (clk),
        .reset (reset),
        .req_i (reg_req),
        .rsp_o (reg_rsp)
    );

endmodule

// ==== verif/dbg_top_properties.sv ====
/*
 * Concurrent checks on the internal Wishbone bus and the tx byte channel
 * of the debug access port. Bound into dbg_top below the module.
 */

`timescale 1ns/1ps

module dbg_top_properties (
    input logic                clk,
    input logic                reset,
    input dbg_pkg::wb_req_t    req_i,
    input dbg_pkg::wb_rsp_t    rsp_i,
    input dbg_pkg::comm_byte_t tx_i,
    input logic                tx_ready_i
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        req_i.stb |-> req_i.cyc)
        else $error("wishbone stb high without cyc");

    // request stays put until the slave answers
    stb_held: assert property (@(posedge clk) disable iff (reset)
        req_i.stb && !rsp_i.ack |=> req_i.stb && $stable(req_i.adr) && $stable(req_i.we))
        else $error("wishbone stb or address dropped before ack");

    ack_in_stb: assert property (@(posedge clk) disable iff (reset)
        rsp_i.ack |-> req_i.stb)
        else $error("wishbone ack outside a strobe");

    tx_held: assert property (@(posedge clk) disable iff (reset)
        tx_i.valid && !tx_ready_i |=> tx_i.valid && $stable(tx_i.data))
        else $error("tx byte changed while stalled");

endmodule

bind dbg_top dbg_top_properties u_props (
    .clk        (clk),
    .reset      (reset),
    .req_i      (m_req),
    .rsp_i      (m_rsp),
    .tx_i       (tx_o),
    .tx_ready_i (tx_ready_i)
);

// ==== verif/tb_dbg_top.sv ====
/*
 * Directed testbench for the debug access port. Drives the host byte
 * channel, keeps a byte model of the RAM and register bank and checks replies.
 */

`timescale 1ns/1ps

module tb_dbg_top;
    import dbg_pkg::*;

    // about 350 byte transfers, each well under 20 cycles even with back-pressure
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        reset;
    logic        endian_i;
    comm_byte_t  rx_i;
    logic        rx_ready_o;
    comm_byte_t  tx_o;
    logic        tx_ready_i;

    logic [31:0] rng_state = 32'hd74a_f774;
    logic [31:0] ram_model [256];
    logic [31:0] reg_model [2];
    logic [7:0]  data_buf [256];
    int          bank_writes = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    dbg_top UUT (
        .clk        (clk),
        .reset      (reset),
        .endian_i   (endian_i),
        .rx_i       (rx_i),
        .rx_ready_o (rx_ready_o),
        .tx_o       (tx_o),
        .tx_ready_i (tx_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    // ------------------------------------------------------------------------
    // byte model, offset k sits in lane k or lane 3-k
    // ------------------------------------------------------------------------
    function automatic int lane_of(input logic [31:0] a);
        return endian_i ? 3 - int'(a[1:0]) : int'(a[1:0]);
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [7:0] d);
        int ln;
        ln = lane_of(a);
        if (!a[12]) begin
            ram_model[a[9:2]][ln*8 +: 8] = d;
        end else if (!a[3]) begin
            reg_model[a[2]][ln*8 +: 8] = d;
        end
    endtask

    function automatic logic [7:0] model_read(input logic [31:0] a);
        logic [31:0] w;
        if (!a[12]) begin
            w = ram_model[a[9:2]];
        end else begin
            case (a[3:2])
            2'd2:    w = 32'h5a3c_0001;
            2'd3:    w = 32'(bank_writes);
            default: w = reg_model[a[2]];
            endcase
        end
        return w[lane_of(a)*8 +: 8];
    endfunction

    task automatic fill_random(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_random();
            data_buf[i] = r[15:8];
        end
    endtask

    // ------------------------------------------------------------------------
    // byte channel, entered and left on a falling edge
    // ------------------------------------------------------------------------
    task automatic send_byte(input logic [7:0] d);
        rx_i.data  = d;
        rx_i.valid = 1'b1;
        while (!rx_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        rx_i.valid = 1'b0;
    endtask

    task automatic recv_byte(input logic [7:0] exp, input bit bp);
        logic [31:0] r;
        logic [7:0]  got;
        bit          taken;
        taken = 1'b0;
        got   = 8'h00;
        while (!taken) begin
            r = next_random();
            tx_ready_i = bp ? r[7] : 1'b1;
            if (tx_o.valid && tx_ready_i) begin
                got   = tx_o.data;
                taken = 1'b1;
            end
            @(negedge clk);
        end
        tx_ready_i = 1'b0;
        check_value("tx_o.data", 32'(got), 32'(exp));
    endtask

    task automatic send_address(input logic [31:0] a);
        for (int i = 0; i < 4; i++) begin
            send_byte(endian_i ? a[(3 - i)*8 +: 8] : a[i*8 +: 8]);
        end
    endtask

    task automatic write_bytes(input logic [31:0] a, input int n);
        logic [31:0] ba;
        send_byte(CMD_WRITE);
        recv_byte(CMD_WRITE ^ 8'h80, 1'b0);
        send_address(a);
        send_byte(8'(n));
        for (int i = 0; i < n; i++) begin
            ba = a + 32'(i);
            send_byte(data_buf[i]);
            model_write(ba, data_buf[i]);
            // one bus write per touched word
            if (ba[12] && (i == 0 || ba[1:0] == 2'd0)) begin
                bank_writes++;
            end
        end
        recv_byte(ACK_WRITE_END, 1'b0);
    endtask

    task automatic read_bytes(input logic [31:0] a, input int n, input bit bp);
        send_byte(CMD_READ);
        recv_byte(CMD_READ ^ 8'h80, 1'b0);
        send_address(a);
        send_byte(8'(n));
        for (int i = 0; i < n; i++) begin
            recv_byte(model_read(a + 32'(i)), bp);
        end
        // nothing beyond the requested count
        repeat (2) @(negedge clk);
        check_value("tx_o.valid", 32'(tx_o.valid), 32'd0);
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_simple_commands();
        send_byte(CMD_NOP);
        recv_byte(8'h80, 1'b0);
        send_byte(CMD_STATUS);
        recv_byte(8'h81, 1'b0);
        recv_byte(8'h24, 1'b0);
        endian_i = 1'b1;
        send_byte(CMD_STATUS);
        recv_byte(8'h81, 1'b0);
        recv_byte(8'ha4, 1'b0);
        endian_i = 1'b0;
        send_byte(8'h55);
        recv_byte(8'hd5, 1'b0);
        send_byte(CMD_NOP);
        recv_byte(8'h80, 1'b0);
    endtask

    task automatic test_ram_writes();
        fill_random(16);
        write_bytes(32'h0000_0000, 16);
        read_bytes(32'h0000_0000, 16, 1'b0);
        fill_random(8);
        write_bytes(32'h0000_0020, 8);
        // partial word in the middle, neighbors must survive
        fill_random(3);
        write_bytes(32'h0000_0021, 3);
        read_bytes(32'h0000_0020, 8, 1'b0);
    endtask

    task automatic test_reg_bank();
        read_bytes(32'h0000_1008, 4, 1'b0);
        fill_random(8);
        write_bytes(32'h0000_1008, 4);
        read_bytes(32'h0000_1008, 4, 1'b0);
        write_bytes(32'h0000_1000, 8);
        read_bytes(32'h0000_1000, 8, 1'b0);
        read_bytes(32'h0000_100c, 4, 1'b0);
    endtask

    task automatic test_backpressure();
        fill_random(40);
        write_bytes(32'h0000_0102, 40);
        read_bytes(32'h0000_0102, 40, 1'b1);
    endtask

    task automatic test_big_endian();
        fill_random(8);
        write_bytes(32'h0000_0040, 4);
        write_bytes(32'h0000_0080, 8);
        endian_i = 1'b1;
        read_bytes(32'h0000_0040, 4, 1'b0);
        fill_random(6);
        write_bytes(32'h0000_0081, 6);
        read_bytes(32'h0000_0081, 6, 1'b1);
        endian_i = 1'b0;
        read_bytes(32'h0000_0080, 8, 1'b0);
    endtask

    initial begin
        reset      = 1'b1;
        endian_i   = 1'b0;
        rx_i       = '0;
        tx_ready_i = 1'b0;
        reg_model[0] = '0;
        reg_model[1] = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_value("tx_o.valid", 32'(tx_o.valid), 32'd0);
        check_value("rx_ready_o", 32'(rx_ready_o), 32'd1);

        test_simple_commands();
        test_ram_writes();
        test_reg_bank();
        test_backpressure();
        test_big_endian();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/dbg_pkg.sv
rtl/dbg_comm_bridge.sv
rtl/dbg_scratch_ram.sv
rtl/dbg_reg_bank.sv
rtl/dbg_wb_decoder.sv
rtl/dbg_top.sv
verif/dbg_top_properties.sv
verif/tb_dbg_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the debug access port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_dbg_top -f vlog.f -o Vtb_dbg_top

sim_out=$(./obj_dir/Vtb_dbg_top 2>&1 || true)
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
